//--- Makefile
VERILATOR ?= verilator
TOP       ?= rename_tb
BUILD     ?= obj_dir
LOG       ?= sim.log
FLIST     ?= flist.f
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FLIST)) include/rename_defs.svh
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: $(BIN)
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Simulation finished: FAIL" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- flist.f
+incdir+include
logic/rv32i_pkg.sv
logic/rename_pkg.sv
logic/rename_if.sv
logic/rename_ctrl.sv
logic/rob_alloc_counter.sv
logic/reg_alias_table.sv
logic/free_list.sv
logic/rename_dispatch.sv
logic/rename_top.sv
tb/rename_asserts.sv
tb/rename_tb.sv

//--- include/rename_defs.svh
// Sizes assume powers of two and a free list of exactly ARCH_REGS slots (PR_ENTRIES = 2*ARCH_REGS)
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// Physical and architectural register file sizes
`define PR_ENTRIES 64
`define ARCH_REGS  32

// Reorder buffer depth, ids wrap at this value
`define ROB_DEPTH  8

// Free list holds every register not in the reset identity map
`define FL_SLOTS   (`PR_ENTRIES - `ARCH_REGS)

// Index widths
`define PREG_W     ($clog2(`PR_ENTRIES))
`define AREG_W     ($clog2(`ARCH_REGS))
`define ROB_W      ($clog2(`ROB_DEPTH))
`define FL_W       ($clog2(`FL_SLOTS))

`endif

//--- logic/free_list.sv
// Slot count must be a power of two; empty means nothing left after this cycle's pop
`timescale 1ns/100ps
`include "rename_defs.svh"

module free_list (
    input  logic               clk,
    input  logic               rst,
    input  logic               sweep_en,
    input  logic [`AREG_W-1:0] sweep_idx,
    input  logic               pop,
    output logic [`PREG_W-1:0] head_preg,
    input  logic               push,
    input  logic [`PREG_W-1:0] push_preg,
    output logic               empty
);

    logic [`PREG_W-1:0] mem [`FL_SLOTS];
    logic [`FL_W-1:0]   head;
    logic [`FL_W-1:0]   tail;
    logic [`FL_W:0]     count;
    logic [`FL_W:0]     count_next;

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (pop && !push) begin
            count_next = count - 1'b1;
        end
    end

    // Sweep loads p32..p63 in order
    always_ff @(posedge clk) begin
        if (sweep_en) begin
            mem[`FL_W'(sweep_idx)] <= `PREG_W'(`ARCH_REGS) + `PREG_W'(sweep_idx);
        end else if (push) begin
            mem[tail] <= push_preg;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (sweep_en) begin
            // Pointers stay at zero, tail wraps back to head once full
            count <= count + 1'b1;
        end else begin
            if (pop) begin
                head <= head + 1'b1;
            end
            if (push) begin
                tail <= tail + 1'b1;
            end
            count <= count_next;
        end
    end

    assign head_preg = mem[head];
    assign empty     = (count_next == '0);

endmodule : free_list

//--- logic/reg_alias_table.sv
// Map is valid only after the init sweep; x0 stays mapped to p0 since rd=x0 is never renamed
`timescale 1ns/100ps
`include "rename_defs.svh"

module reg_alias_table (
    input  logic               clk,
    input  logic               rst,
    rat_lookup_if.tbl          rat,
    input  logic               sweep_en,
    input  logic [`AREG_W-1:0] sweep_idx,
    input  logic               wb_valid,
    input  logic [`PREG_W-1:0] wb_preg
);

    logic [`PREG_W-1:0]    map [`ARCH_REGS];
    logic [`PR_ENTRIES-1:0] busy;

    // Map contents, filled by the sweep then rewritten per rename
    always_ff @(posedge clk) begin
        if (sweep_en) begin
            map[sweep_idx] <= `PREG_W'(sweep_idx);
        end else if (rat.map_we) begin
            map[rat.areg_rd] <= rat.new_preg;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || sweep_en) begin
            busy <= '0;
        end else begin
            if (wb_valid) begin
                busy[wb_preg] <= 1'b0;
            end
            // New destination is waiting on its producer
            if (rat.map_we) begin
                busy[rat.new_preg] <= 1'b1;
            end
        end
    end

    assign rat.preg_rs1 = map[rat.areg_rs1];
    assign rat.preg_rs2 = map[rat.areg_rs2];
    assign rat.old_preg = map[rat.areg_rd];

    // Writeback this cycle counts as done
    assign rat.rs1_busy = busy[rat.preg_rs1] & ~(wb_valid && wb_preg == rat.preg_rs1);
    assign rat.rs2_busy = busy[rat.preg_rs2] & ~(wb_valid && wb_preg == rat.preg_rs2);

endmodule : reg_alias_table

//--- logic/rename_ctrl.sv
// fl_empty and rob_full must already account for the dispatch in flight this cycle
`timescale 1ns/100ps
`include "rename_defs.svh"

module rename_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               inst_q_empty,
    input  logic               rs_full,
    input  logic               fl_empty,
    input  logic               rob_full,
    output logic               pop_inst_q,
    output logic               sweep_en,
    output logic [`AREG_W-1:0] sweep_idx,
    output logic               rename_ready
);

    rename_pkg::ctrl_state_e state;
    logic                    go;

    // Every resource the next instruction will need is available
    assign go = ~inst_q_empty & ~rs_full & ~fl_empty & ~rob_full;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= rename_pkg::st_init;
            sweep_idx <= '0;
        end else begin
            case (state)
                rename_pkg::st_init: begin
                    sweep_idx <= sweep_idx + 1'b1;
                    // Last architectural register loaded
                    if (sweep_idx == `AREG_W'(`ARCH_REGS - 1)) begin
                        state <= rename_pkg::st_run;
                    end
                end
                rename_pkg::st_run,
                rename_pkg::st_stall: begin
                    state <= go ? rename_pkg::st_run : rename_pkg::st_stall;
                end
                default: begin
                    state <= rename_pkg::st_init;
                end
            endcase
        end
    end

    assign sweep_en     = (state == rename_pkg::st_init);
    assign rename_ready = ~sweep_en;
    assign pop_inst_q   = rename_ready & go;

endmodule : rename_ctrl

//--- logic/rename_dispatch.sv
// Instruction inputs must hold the popped entry in the cycle after the pop
`timescale 1ns/100ps
`include "rename_defs.svh"

module rename_dispatch (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        pop_inst_q,
    input  rv32i_pkg::queue_inst_t      inst,
    rat_lookup_if.dispatch              rat,
    input  logic [`PREG_W-1:0]          fl_head,
    input  logic [`ROB_W-1:0]           rob_id_next,
    output logic                        fl_pop,
    output logic                        rob_alloc,
    output logic                        disp_valid,
    output rename_pkg::dispatch_entry_t entry
);

    logic               valid_q;
    logic               rs1_needed;
    logic               rs2_needed;
    logic               rd_needed;
    logic               rd_rename;
    logic [`AREG_W-1:0] rs1_a;
    logic [`AREG_W-1:0] rs2_a;
    logic [`AREG_W-1:0] rd_a;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= pop_inst_q;
        end
    end

    // Opcode picks the view and which registers matter
    always_comb begin
        rs1_needed = 1'b0;
        rs2_needed = 1'b0;
        rd_needed  = 1'b0;
        rs1_a      = inst.word.r.rs1;
        rs2_a      = '0;
        rd_a       = '0;
        case (inst.word.r.opcode)
            rv32i_pkg::op_lui, rv32i_pkg::op_auipc, rv32i_pkg::op_jal: begin
                rd_needed = 1'b1;
                rd_a      = inst.word.r.rd;
            end
            rv32i_pkg::op_jalr, rv32i_pkg::op_load, rv32i_pkg::op_imm: begin
                rs1_needed = 1'b1;
                rd_needed  = 1'b1;
                rd_a       = inst.word.r.rd;
            end
            rv32i_pkg::op_store, rv32i_pkg::op_branch: begin
                // Bits 11:7 are immediate here
                rs1_needed = 1'b1;
                rs2_needed = 1'b1;
                rs1_a      = inst.word.s.rs1;
                rs2_a      = inst.word.s.rs2;
            end
            rv32i_pkg::op_reg: begin
                rs1_needed = 1'b1;
                rs2_needed = 1'b1;
                rd_needed  = 1'b1;
                rs2_a      = inst.word.r.rs2;
                rd_a       = inst.word.r.rd;
            end
            default: begin
                rs1_a = '0;
            end
        endcase
    end

    assign rd_rename = rd_needed && (rd_a != '0);

    assign rat.areg_rs1 = rs1_a;
    assign rat.areg_rs2 = rs2_a;
    assign rat.areg_rd  = rd_a;
    assign rat.new_preg = fl_head;
    assign rat.map_we   = valid_q & rd_rename;

    assign fl_pop     = valid_q & rd_rename;
    assign rob_alloc  = valid_q;
    assign disp_valid = valid_q;

    always_comb begin
        entry.rob_id      = rob_id_next;
        entry.rs1_preg    = rat.preg_rs1;
        entry.rs2_preg    = rat.preg_rs2;
        entry.rd_preg     = fl_head;
        entry.old_rd_preg = rat.old_preg;
        entry.rd_valid    = rd_rename;
        // Unused operand is trivially met
        entry.input1_met  = ~rs1_needed | ~rat.rs1_busy;
        entry.input2_met  = ~rs2_needed | ~rat.rs2_busy;
        entry.pc_curr     = inst.pc_curr;
        entry.inst        = inst.word;
    end

endmodule : rename_dispatch

//--- logic/rename_if.sv
// RAT lookup is combinational; map and busy updates land on the edge where map_we is high
`timescale 1ns/100ps
`include "rename_defs.svh"

interface rat_lookup_if;

    logic [`AREG_W-1:0] areg_rs1;
    logic [`AREG_W-1:0] areg_rs2;
    logic [`AREG_W-1:0] areg_rd;
    logic               map_we;
    logic [`PREG_W-1:0] new_preg;
    logic [`PREG_W-1:0] preg_rs1;
    logic [`PREG_W-1:0] preg_rs2;
    logic [`PREG_W-1:0] old_preg;
    logic               rs1_busy;
    logic               rs2_busy;

    modport dispatch (output areg_rs1, areg_rs2, areg_rd, map_we, new_preg,
                      input  preg_rs1, preg_rs2, old_preg, rs1_busy, rs2_busy);

    // Named tbl since table is a reserved word
    modport tbl (input  areg_rs1, areg_rs2, areg_rd, map_we, new_preg,
                 output preg_rs1, preg_rs2, old_preg, rs1_busy, rs2_busy);

endinterface : rat_lookup_if

//--- logic/rename_pkg.sv
// Rename-side types; widths come from rename_defs.svh, instruction word from rv32i_pkg
`include "rename_defs.svh"

package rename_pkg;

    // Controller states
    typedef enum logic [1:0] {
        st_init,
        st_run,
        st_stall
    } ctrl_state_e;

    // Entry handed to the reservation station
    typedef struct packed {
        logic [`ROB_W-1:0]  rob_id;
        logic [`PREG_W-1:0] rs1_preg;
        logic [`PREG_W-1:0] rs2_preg;
        logic [`PREG_W-1:0] rd_preg;
        logic [`PREG_W-1:0] old_rd_preg;
        // Low for STORE, BRANCH and writes to x0
        logic               rd_valid;
        logic               input1_met;
        logic               input2_met;
        logic [31:0]        pc_curr;
        rv32i_pkg::inst_word_u inst;
    } dispatch_entry_t;

endpackage : rename_pkg

//--- logic/rename_top.sv
// Single-issue rename front; disp_* fields are meaningful only while disp_valid is high
`timescale 1ns/100ps
`include "rename_defs.svh"

module rename_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               inst_q_empty,
    input  logic               inst_valid,
    input  logic [31:0]        inst_word,
    input  logic [31:0]        inst_pc,
    input  logic [31:0]        inst_pc_next,
    input  logic               rs_full,
    input  logic               retire,
    input  logic               wb_valid,
    input  logic [`PREG_W-1:0] wb_preg,
    input  logic               free_valid,
    input  logic [`PREG_W-1:0] free_preg,
    output logic               pop_inst_q,
    output logic               rename_ready,
    output logic               disp_valid,
    output logic [`ROB_W-1:0]  disp_rob_id,
    output logic [`PREG_W-1:0] disp_rs1_preg,
    output logic [`PREG_W-1:0] disp_rs2_preg,
    output logic [`PREG_W-1:0] disp_rd_preg,
    output logic [`PREG_W-1:0] disp_old_rd_preg,
    output logic               disp_rd_valid,
    output logic               disp_input1_met,
    output logic               disp_input2_met,
    output logic [31:0]        disp_pc
);

    rv32i_pkg::queue_inst_t      q_inst;
    rename_pkg::dispatch_entry_t entry;
    logic                        fl_empty;
    logic                        rob_full;
    logic                        sweep_en;
    logic [`AREG_W-1:0]          sweep_idx;
    logic [`PREG_W-1:0]          fl_head;
    logic                        fl_pop;
    logic                        rob_alloc;
    logic [`ROB_W-1:0]           rob_id_next;

    rat_lookup_if rat_if ();

    assign q_inst.valid   = inst_valid;
    assign q_inst.word    = inst_word;
    assign q_inst.pc_curr = inst_pc;
    assign q_inst.pc_next = inst_pc_next;

    rename_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .inst_q_empty (inst_q_empty),
        .rs_full      (rs_full),
        .fl_empty     (fl_empty),
        .rob_full     (rob_full),
        .pop_inst_q   (pop_inst_q),
        .sweep_en     (sweep_en),
        .sweep_idx    (sweep_idx),
        .rename_ready (rename_ready)
    );

    rob_alloc_counter u_rob (
        .clk         (clk),
        .rst         (rst),
        .alloc       (rob_alloc),
        .retire      (retire),
        .rob_id_next (rob_id_next),
        .rob_full    (rob_full)
    );

    reg_alias_table u_rat (
        .clk       (clk),
        .rst       (rst),
        .rat       (rat_if.tbl),
        .sweep_en  (sweep_en),
        .sweep_idx (sweep_idx),
        .wb_valid  (wb_valid),
        .wb_preg   (wb_preg)
    );

    free_list u_fl (
        .clk       (clk),
        .rst       (rst),
        .sweep_en  (sweep_en),
        .sweep_idx (sweep_idx),
        .pop       (fl_pop),
        .head_preg (fl_head),
        .push      (free_valid),
        .push_preg (free_preg),
        .empty     (fl_empty)
    );

    rename_dispatch u_disp (
        .clk         (clk),
        .rst         (rst),
        .pop_inst_q  (pop_inst_q),
        .inst        (q_inst),
        .rat         (rat_if.dispatch),
        .fl_head     (fl_head),
        .rob_id_next (rob_id_next),
        .fl_pop      (fl_pop),
        .rob_alloc   (rob_alloc),
        .disp_valid  (disp_valid),
        .entry       (entry)
    );

    assign disp_rob_id      = entry.rob_id;
    assign disp_rs1_preg    = entry.rs1_preg;
    assign disp_rs2_preg    = entry.rs2_preg;
    assign disp_rd_preg     = entry.rd_preg;
    assign disp_old_rd_preg = entry.old_rd_preg;
    assign disp_rd_valid    = entry.rd_valid;
    assign disp_input1_met  = entry.input1_met;
    assign disp_input2_met  = entry.input2_met;
    assign disp_pc          = entry.pc_curr;

endmodule : rename_top

//--- logic/rob_alloc_counter.sv
// Occupancy only; the ROB storage lives outside. rob_full looks ahead past this cycle's alloc
`timescale 1ns/100ps
`include "rename_defs.svh"

module rob_alloc_counter (
    input  logic              clk,
    input  logic              rst,
    input  logic              alloc,
    input  logic              retire,
    output logic [`ROB_W-1:0] rob_id_next,
    output logic              rob_full
);

    logic [`ROB_W-1:0] tail;
    logic [`ROB_W:0]   occ;
    logic [`ROB_W:0]   occ_next;

    always_comb begin
        occ_next = occ;
        if (alloc && !retire) begin
            occ_next = occ + 1'b1;
        end else if (retire && !alloc) begin
            occ_next = occ - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tail <= '0;
            occ  <= '0;
        end else begin
            // Tail wraps on its own at ROB_DEPTH
            if (alloc) begin
                tail <= tail + 1'b1;
            end
            occ <= occ_next;
        end
    end

    assign rob_id_next = tail;
    assign rob_full    = (occ_next == (`ROB_W+1)'(`ROB_DEPTH));

endmodule : rob_alloc_counter

//--- logic/rv32i_pkg.sv
// RV32I base opcodes only; no compressed, system or fence encodings are recognized
package rv32i_pkg;

    // Major opcodes, bits 6:0
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_e;

    // Register format, also the view used for any writing instruction
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } rtype_t;

    // Store format, BRANCH shares the register positions
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } stype_t;

    typedef union packed {
        rtype_t r;
        stype_t s;
    } inst_word_u;

    // One entry as it sits in the instruction queue
    typedef struct packed {
        logic       valid;
        inst_word_u word;
        logic [31:0] pc_curr;
        logic [31:0] pc_next;
    } queue_inst_t;

endpackage : rv32i_pkg

//--- tb/rename_asserts.sv
// Protocol checks sampled on the rising edge; all are disabled while rst is high
`timescale 1ns/100ps
`include "rename_defs.svh"

module rename_asserts (
    input logic               clk,
    input logic               rst,
    input logic               pop_inst_q,
    input logic               rs_full,
    input logic               rename_ready,
    input logic               disp_valid,
    input logic               disp_rd_valid,
    input logic [`PREG_W-1:0] disp_rd_preg
);

    // Failed assertions so far
    int fail_count = 0;

    // Dispatch strobe is the pop delayed by one cycle
    disp_follows_pop: assert property (@(posedge clk) disable iff (rst)
        disp_valid == $past(pop_inst_q))
        else begin
            $error("disp_valid does not follow pop_inst_q by one cycle");
            fail_count++;
        end

    no_pop_when_rs_full: assert property (@(posedge clk) disable iff (rst)
        !(pop_inst_q && rs_full))
        else begin
            $error("pop_inst_q high while rs_full is high");
            fail_count++;
        end

    no_pop_before_ready: assert property (@(posedge clk) disable iff (rst)
        !(pop_inst_q && !rename_ready))
        else begin
            $error("pop_inst_q high before rename_ready");
            fail_count++;
        end

    // Renamed destinations come only from the upper half
    rd_from_free_pool: assert property (@(posedge clk) disable iff (rst)
        (disp_valid && disp_rd_valid) |-> disp_rd_preg >= `PREG_W'(`ARCH_REGS))
        else begin
            $error("disp_rd_preg below the free pool range");
            fail_count++;
        end

endmodule : rename_asserts

bind rename_top rename_asserts u_asserts (.*);

//--- tb/rename_tb.sv
// Drives the DUT from a queue of encoded instructions and checks every dispatch against a model
`timescale 1ns/100ps
`include "rename_defs.svh"

module rename_tb;

    localparam int TOTAL_CYC = 480;

    logic               clk;
    logic               rst;
    logic               inst_q_empty;
    logic               inst_valid;
    logic [31:0]        inst_word;
    logic [31:0]        inst_pc;
    logic [31:0]        inst_pc_next;
    logic               rs_full;
    logic               retire;
    logic               wb_valid;
    logic [`PREG_W-1:0] wb_preg;
    logic               free_valid;
    logic [`PREG_W-1:0] free_preg;
    logic               pop_inst_q;
    logic               rename_ready;
    logic               disp_valid;
    logic [`ROB_W-1:0]  disp_rob_id;
    logic [`PREG_W-1:0] disp_rs1_preg;
    logic [`PREG_W-1:0] disp_rs2_preg;
    logic [`PREG_W-1:0] disp_rd_preg;
    logic [`PREG_W-1:0] disp_old_rd_preg;
    logic               disp_rd_valid;
    logic               disp_input1_met;
    logic               disp_input2_met;
    logic [31:0]        disp_pc;

    // Model state
    int          map_m [`ARCH_REGS];
    bit          busy_m [`PR_ENTRIES];
    int          fl_m [$];
    int          recycle [$];
    int          rob_tail;
    int          rob_cnt;
    logic [31:0] inst_q [$];
    logic [31:0] pc_q [$];
    bit          pop_pred;
    bit          auto_retire;
    bit          auto_free;
    bit          rs_hold;
    bit          wb_on;
    int          wb_reg;
    int          cyc;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          err_mark;

    rename_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #((TOTAL_CYC + 5 + 50) * 10);
        $display("Watchdog expired before the tests completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic logic [31:0] enc(logic [6:0] op, logic [4:0] rd, logic [4:0] rs1,
                                        logic [4:0] rs2, logic [6:0] f7);
        return {f7, rs2, rs1, 3'b000, rd, op};
    endfunction

    // {rs1 used, rs2 used, rd written} per major opcode
    function automatic logic [2:0] operands_used(logic [6:0] op);
        case (op)
            rv32i_pkg::op_lui, rv32i_pkg::op_auipc, rv32i_pkg::op_jal: return 3'b001;
            rv32i_pkg::op_jalr, rv32i_pkg::op_load, rv32i_pkg::op_imm: return 3'b101;
            rv32i_pkg::op_store, rv32i_pkg::op_branch: return 3'b110;
            rv32i_pkg::op_reg: return 3'b111;
            default: return 3'b000;
        endcase
    endfunction

    // Model mismatches plus failures of the bound protocol assertions
    function automatic int total_errors();
        return errors + DUT.u_asserts.fail_count;
    endfunction

    task automatic compare_field(string name, int exp, int got);
        assert (exp == got) else begin
            $display("ERR t=%0t %s expected %0d got %0d", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic enqueue(logic [31:0] w);
        inst_q.push_back(w);
        pc_q.push_back(32'h1000 + 32'(4 * inst_q.size()));
    endtask

    task automatic check_dispatch();
        logic [2:0] use_m;
        int         rs1;
        int         rs2;
        int         rd;
        bit         ren;
        int         newp;
        use_m = operands_used(inst_word[6:0]);
        rs1   = int'(inst_word[19:15]);
        rs2   = int'(inst_word[24:20]);
        rd    = int'(inst_word[11:7]);
        ren   = use_m[0] && rd != 0;
        compare_field("disp_rob_id", rob_tail, int'(disp_rob_id));
        if (use_m[2]) compare_field("disp_rs1_preg", map_m[rs1], int'(disp_rs1_preg));
        if (use_m[1]) compare_field("disp_rs2_preg", map_m[rs2], int'(disp_rs2_preg));
        compare_field("disp_input1_met", int'(!use_m[2] || !busy_m[map_m[rs1]]),
                      int'(disp_input1_met));
        compare_field("disp_input2_met", int'(!use_m[1] || !busy_m[map_m[rs2]]),
                      int'(disp_input2_met));
        compare_field("disp_rd_valid", int'(ren), int'(disp_rd_valid));
        compare_field("disp_pc", int'(inst_pc), int'(disp_pc));
        if (ren) begin
            newp = fl_m.pop_front();
            compare_field("disp_rd_preg", newp, int'(disp_rd_preg));
            compare_field("disp_old_rd_preg", map_m[rd], int'(disp_old_rd_preg));
            if (map_m[rd] >= `ARCH_REGS) recycle.push_back(map_m[rd]);
            map_m[rd]    = newp;
            busy_m[newp] = 1'b1;
        end
        rob_tail = (rob_tail + 1) % `ROB_DEPTH;
        rob_cnt++;
    endtask

    // One clock: drive on the falling edge, then check once outputs settle
    task automatic step();
        bit inflight;
        bit exp_pop;
        @(negedge clk);
        cyc++;
        inflight = pop_pred;
        if (inflight) begin
            inst_word = inst_q.pop_front();
            inst_pc   = pc_q.pop_front();
        end
        inst_q_empty = (inst_q.size() == 0);
        rs_full      = rs_hold;
        retire       = auto_retire && rob_cnt > 0;
        wb_valid     = wb_on;
        wb_preg      = `PREG_W'(wb_reg);
        free_valid   = auto_free && recycle.size() > 0;
        if (free_valid) free_preg = `PREG_W'(recycle.pop_front());
        #1;
        if (wb_valid) busy_m[wb_reg] = 1'b0;
        compare_field("disp_valid", int'(inflight), int'(disp_valid));
        if (inflight) check_dispatch();
        if (free_valid) fl_m.push_back(int'(free_preg));
        if (retire) rob_cnt--;
        compare_field("rename_ready", int'(cyc >= `ARCH_REGS), int'(rename_ready));
        exp_pop = cyc >= `ARCH_REGS && !inst_q_empty && !rs_full &&
                  fl_m.size() > 0 && rob_cnt < `ROB_DEPTH;
        compare_field("pop_inst_q", int'(exp_pop), int'(pop_inst_q));
        pop_pred = pop_inst_q;
    endtask

    task automatic run_steps(int n);
        repeat (n) step();
    endtask

    task automatic drain(int cap);
        int n;
        n = 0;
        do begin
            step();
            n++;
        end while ((inst_q.size() != 0 || pop_pred) && n < cap);
        if (inst_q.size() != 0 || pop_pred) begin
            $display("Queue did not drain within %0d cycles", cap);
            errors++;
        end
    endtask

    task automatic report(string name);
        int total;
        total = total_errors();
        tests_run++;
        if (total != err_mark) tests_failed++;
        $display("test %-14s %s (%0d errors)", name,
                 (total == err_mark) ? "ok" : "FAILED", total - err_mark);
        err_mark = total;
    endtask

    initial begin
        void'($urandom(73));
        rst = 1'b1;
        inst_q_empty = 1'b1;
        inst_valid = 1'b1;
        inst_word = '0;
        inst_pc = '0;
        inst_pc_next = '0;
        rs_full = 1'b0;
        retire = 1'b0;
        wb_valid = 1'b0;
        wb_preg = '0;
        free_valid = 1'b0;
        free_preg = '0;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            map_m[i] = i;
            fl_m.push_back(`ARCH_REGS + i);
        end
        foreach (busy_m[i]) busy_m[i] = 1'b0;
        auto_retire = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        cyc = 0;

        // Queue is full from the start, pops must wait for the sweep
        for (int i = 1; i <= 3; i++) enqueue(enc(rv32i_pkg::op_reg, 5'(i), 5'd5, 5'd6, 7'd0));
        drain(80);
        report("init_order");

        for (int i = 0; i < 10; i++)
            enqueue(enc(rv32i_pkg::op_lui, 5'($urandom_range(1, 31)), 5'd0, 5'd0, 7'd0));
        drain(40);
        report("rob_wrap");

        enqueue(enc(rv32i_pkg::op_reg, 5'd1, 5'd2, 5'd3, 7'd0));
        enqueue(enc(rv32i_pkg::op_imm, 5'd8, 5'd1, 5'd0, 7'd0));
        drain(20);
        wb_reg = map_m[1];
        enqueue(enc(rv32i_pkg::op_reg, 5'd9, 5'd1, 5'd1, 7'd0));
        step();
        // Writeback lands in the reader's dispatch cycle
        wb_on = 1'b1;
        step();
        wb_on = 1'b0;
        drain(20);
        enqueue(enc(rv32i_pkg::op_reg, 5'd10, 5'd2, 5'd1, 7'd0));
        drain(20);
        report("dependency");

        rs_hold = 1'b1;
        enqueue(enc(rv32i_pkg::op_reg, 5'd2, 5'd1, 5'd3, 7'd0));
        enqueue(enc(rv32i_pkg::op_reg, 5'd3, 5'd2, 5'd1, 7'd0));
        run_steps(6);
        rs_hold = 1'b0;
        drain(20);
        auto_retire = 1'b0;
        for (int i = 0; i < 12; i++) enqueue(enc(rv32i_pkg::op_jal, 5'd1 + 5'(i % 3), 5'd0,
                                                 5'd0, 7'd0));
        run_steps(20);
        auto_retire = 1'b1;
        drain(40);
        report("backpressure");

        enqueue(enc(rv32i_pkg::op_store, 5'd17, 5'd1, 5'd2, 7'd3));
        enqueue(enc(rv32i_pkg::op_branch, 5'd9, 5'd3, 5'd1, 7'd0));
        enqueue(enc(rv32i_pkg::op_reg, 5'd0, 5'd1, 5'd2, 7'd0));
        enqueue(enc(rv32i_pkg::op_imm, 5'd4, 5'd2, 5'd1, 7'd5));
        drain(20);
        report("formats");

        // Only already-renamed registers are written so every old mapping is recyclable
        for (int i = 0; i < 40; i++)
            enqueue(enc(rv32i_pkg::op_imm, 5'($urandom_range(1, 3)), 5'd2, 5'd0, 7'd0));
        run_steps(60);
        auto_free = 1'b1;
        drain(120);
        report("free_list");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 total_errors());
        if (total_errors() == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : rename_tb
